/* design/rob_pkg.sv */
// Reorder buffer shared definitions
package rob_pkg;

   // One issue and one commit lane per bank
   localparam int P_BANKS = 2;
   localparam int BANKS = 1 << P_BANKS;

   // Slots held by each bank FIFO
   localparam int P_ROB_DEPTH = 3;
   localparam int ROB_DEPTH = 1 << P_ROB_DEPTH;

   // Writeback ports
   localparam int WB_LANES = 2;

   // Datapath and register file widths
   localparam int DW = 16;
   localparam int PC_W = 16;
   localparam int LRF_AW = 5;
   localparam int PRF_AW = 6;

   // Written at issue and read back at commit
   typedef struct packed {
      logic [PC_W-1:0]   pc;
      logic [LRF_AW-1:0] lrd;
      logic [PRF_AW-1:0] prd;
      logic              prd_we;
      logic [PRF_AW-1:0] pfree;
   } rob_entry_t;

   // Result word written at writeback
   typedef logic [DW-1:0] rob_value_t;

endpackage

/* design/rob_slot_ram.sv */
// Reorder buffer slot memory
`timescale 1ns/1ns

module rob_slot_ram
#(
   parameter type T = rob_pkg::rob_value_t
)
(
   input  logic                         clk,
   input  logic                         we,
   input  logic [rob_pkg::P_ROB_DEPTH-1:0] waddr,
   input  T                             wdata,
   input  logic [rob_pkg::P_ROB_DEPTH-1:0] raddr,
   output T                             rdata
);

   T mem [rob_pkg::ROB_DEPTH];

   // Registered write
   always_ff @(posedge clk)
   begin
      if (we)
         mem[waddr] <= wdata;
   end

   // Read is asynchronous so the head entry shows without a bubble
   assign rdata = mem[raddr];

endmodule

/* design/rob_bank.sv */
// Reorder buffer bank
`timescale 1ns/1ns

module rob_bank
(
   input  logic                            clk,
   input  logic                            rst_n,
   input  logic                            flush,
   input  logic                            push,
   input  rob_pkg::rob_entry_t             push_entry,
   input  logic                            pop,
   input  logic                            wb,
   input  logic [rob_pkg::P_ROB_DEPTH-1:0] wb_id,
   input  logic                            wb_fls,
   input  logic                            wb_exc,
   input  rob_pkg::rob_value_t             wb_value,
   output logic                            not_full,
   output logic [rob_pkg::P_ROB_DEPTH-1:0] wr_slot,
   output logic                            head_valid,
   output rob_pkg::rob_entry_t             head_entry,
   output logic                            head_fls,
   output logic                            head_exc,
   output rob_pkg::rob_value_t             head_value
);

   logic [rob_pkg::P_ROB_DEPTH-1:0] wr_ptr;
   logic [rob_pkg::P_ROB_DEPTH-1:0] rd_ptr;
   logic [rob_pkg::P_ROB_DEPTH:0]   count;
   logic [rob_pkg::P_ROB_DEPTH:0]   count_nxt;
   logic [rob_pkg::ROB_DEPTH-1:0]   tag_rdy;
   logic [rob_pkg::ROB_DEPTH-1:0]   tag_fls;
   logic [rob_pkg::ROB_DEPTH-1:0]   tag_exc;

   always_comb
   begin
      count_nxt = count;
      if (push && !pop)
         count_nxt = count + 1'b1;
      else if (pop && !push)
         count_nxt = count - 1'b1;
   end

   // FIFO pointers
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end
      else if (flush)
      begin
         wr_ptr <= '0;
         rd_ptr <= '0;
         count <= '0;
      end
      else
      begin
         if (push)
            wr_ptr <= wr_ptr + 1'b1;
         if (pop)
            rd_ptr <= rd_ptr + 1'b1;
         count <= count_nxt;
      end
   end

   // Per-slot completion tags cleared when a slot takes a new entry
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         tag_rdy <= '0;
         tag_fls <= '0;
         tag_exc <= '0;
      end
      else if (flush)
      begin
         tag_rdy <= '0;
         tag_fls <= '0;
         tag_exc <= '0;
      end
      else
      begin
         if (push)
         begin
            tag_rdy[wr_ptr] <= 1'b0;
            tag_fls[wr_ptr] <= 1'b0;
            tag_exc[wr_ptr] <= 1'b0;
         end
         if (wb)
         begin
            tag_rdy[wb_id] <= 1'b1;
            tag_fls[wb_id] <= wb_fls;
            tag_exc[wb_id] <= wb_exc;
         end
      end
   end

   rob_slot_ram #(.T(rob_pkg::rob_entry_t)) i_entry_ram (
      .clk   (clk),
      .we    (push),
      .waddr (wr_ptr),
      .wdata (push_entry),
      .raddr (rd_ptr),
      .rdata (head_entry)
   );

   rob_slot_ram #(.T(rob_pkg::rob_value_t)) i_value_ram (
      .clk   (clk),
      .we    (wb),
      .waddr (wb_id),
      .wdata (wb_value),
      .raddr (rd_ptr),
      .rdata (head_value)
   );

   // Count MSB set means all eight slots taken
   assign not_full = ~count[rob_pkg::P_ROB_DEPTH];
   assign wr_slot = wr_ptr;
   assign head_valid = (count != '0) & tag_rdy[rd_ptr];
   assign head_fls = tag_fls[rd_ptr];
   assign head_exc = tag_exc[rd_ptr];

endmodule

/* design/rob_wb_route.sv */
// Writeback lane to bank steering
`timescale 1ns/1ns

module rob_wb_route
(
   input  logic [rob_pkg::WB_LANES-1:0]                            wb_valid,
   input  logic [rob_pkg::WB_LANES-1:0][rob_pkg::P_BANKS-1:0]     wb_rob_bank,
   input  logic [rob_pkg::WB_LANES-1:0][rob_pkg::P_ROB_DEPTH-1:0] wb_rob_id,
   input  logic [rob_pkg::WB_LANES-1:0]                            wb_fls,
   input  logic [rob_pkg::WB_LANES-1:0]                            wb_exc,
   input  rob_pkg::rob_value_t [rob_pkg::WB_LANES-1:0]             wb_value,
   output logic [rob_pkg::BANKS-1:0]                               bank_wb,
   output logic [rob_pkg::BANKS-1:0][rob_pkg::P_ROB_DEPTH-1:0]    bank_wb_id,
   output logic [rob_pkg::BANKS-1:0]                               bank_wb_fls,
   output logic [rob_pkg::BANKS-1:0]                               bank_wb_exc,
   output rob_pkg::rob_value_t [rob_pkg::BANKS-1:0]                bank_wb_value
);

   // At most one valid lane names a bank per cycle, so OR-merge is enough
   always_comb
   begin
      logic hit;

      bank_wb = '0;
      bank_wb_id = '0;
      bank_wb_fls = '0;
      bank_wb_exc = '0;
      bank_wb_value = '0;
      for (int b = 0; b < rob_pkg::BANKS; b++)
      begin
         for (int l = 0; l < rob_pkg::WB_LANES; l++)
         begin
            // Invalid lanes must not leak their fields
            hit = wb_valid[l] & (wb_rob_bank[l] == b[rob_pkg::P_BANKS-1:0]);
            bank_wb[b] = bank_wb[b] | hit;
            bank_wb_id[b] = bank_wb_id[b] |
                            ({rob_pkg::P_ROB_DEPTH{hit}} & wb_rob_id[l]);
            bank_wb_fls[b] = bank_wb_fls[b] | (hit & wb_fls[l]);
            bank_wb_exc[b] = bank_wb_exc[b] | (hit & wb_exc[l]);
            bank_wb_value[b] = bank_wb_value[b] |
                               ({rob_pkg::DW{hit}} & wb_value[l]);
         end
      end
   end

endmodule

/* design/rob_ring_ctrl.sv */
// Reorder buffer head and tail ring control
`timescale 1ns/1ns

module rob_ring_ctrl
(
   input  logic                                                 clk,
   input  logic                                                 rst_n,
   input  logic                                                 flush,
   input  logic [rob_pkg::P_BANKS:0]                            push_size,
   input  logic [rob_pkg::P_BANKS:0]                            pop_size,
   input  logic [rob_pkg::BANKS-1:0][rob_pkg::PC_W-1:0]         push_pc,
   input  logic [rob_pkg::BANKS-1:0][rob_pkg::LRF_AW-1:0]       push_lrd,
   input  logic [rob_pkg::BANKS-1:0][rob_pkg::PRF_AW-1:0]       push_prd,
   input  logic [rob_pkg::BANKS-1:0]                            push_prd_we,
   input  logic [rob_pkg::BANKS-1:0][rob_pkg::PRF_AW-1:0]       push_pfree,
   input  logic [rob_pkg::BANKS-1:0][rob_pkg::P_ROB_DEPTH-1:0]  bank_wr_slot,
   output logic [rob_pkg::BANKS-1:0]                            bank_push,
   output rob_pkg::rob_entry_t [rob_pkg::BANKS-1:0]             bank_push_entry,
   output logic [rob_pkg::BANKS-1:0]                            bank_pop,
   output logic [rob_pkg::BANKS-1:0][rob_pkg::P_ROB_DEPTH-1:0]  free_id,
   output logic [rob_pkg::BANKS-1:0][rob_pkg::P_BANKS-1:0]      free_bank,
   input  logic [rob_pkg::BANKS-1:0]                            bank_head_valid,
   input  rob_pkg::rob_entry_t [rob_pkg::BANKS-1:0]             bank_head_entry,
   input  logic [rob_pkg::BANKS-1:0]                            bank_head_fls,
   input  logic [rob_pkg::BANKS-1:0]                            bank_head_exc,
   input  rob_pkg::rob_value_t [rob_pkg::BANKS-1:0]             bank_head_value,
   output logic [rob_pkg::BANKS-1:0]                            cmt_valid,
   output logic [rob_pkg::BANKS-1:0][rob_pkg::PC_W-1:0]         cmt_pc,
   output logic [rob_pkg::BANKS-1:0][rob_pkg::LRF_AW-1:0]       cmt_lrd,
   output logic [rob_pkg::BANKS-1:0][rob_pkg::PRF_AW-1:0]       cmt_prd,
   output logic [rob_pkg::BANKS-1:0]                            cmt_prd_we,
   output logic [rob_pkg::BANKS-1:0][rob_pkg::PRF_AW-1:0]       cmt_pfree,
   output logic [rob_pkg::BANKS-1:0]                            cmt_fls,
   output logic [rob_pkg::BANKS-1:0]                            cmt_exc,
   output rob_pkg::rob_value_t [rob_pkg::BANKS-1:0]             cmt_value
);

   logic [rob_pkg::P_BANKS-1:0]                 head_q;
   logic [rob_pkg::P_BANKS-1:0]                 tail_q;
   rob_pkg::rob_entry_t [rob_pkg::BANKS-1:0]    lane_entry;

   // Size of 4 wraps the 2-bit pointer back onto itself
   always_ff @(posedge clk or negedge rst_n)
   begin
      if (!rst_n)
      begin
         head_q <= '0;
         tail_q <= '0;
      end
      else if (flush)
      begin
         head_q <= '0;
         tail_q <= '0;
      end
      else
      begin
         head_q <= head_q + pop_size[rob_pkg::P_BANKS-1:0];
         tail_q <= tail_q + push_size[rob_pkg::P_BANKS-1:0];
      end
   end

   // Issue lanes packed into entries
   always_comb
   begin
      for (int k = 0; k < rob_pkg::BANKS; k++)
      begin
         lane_entry[k].pc = push_pc[k];
         lane_entry[k].lrd = push_lrd[k];
         lane_entry[k].prd = push_prd[k];
         lane_entry[k].prd_we = push_prd_we[k];
         lane_entry[k].pfree = push_pfree[k];
      end
   end

   // Bank strobes from distance past tail and head
   always_comb
   begin
      logic [rob_pkg::P_BANKS-1:0] tail_dist;
      logic [rob_pkg::P_BANKS-1:0] head_dist;

      for (int b = 0; b < rob_pkg::BANKS; b++)
      begin
         tail_dist = b[rob_pkg::P_BANKS-1:0] - tail_q;
         head_dist = b[rob_pkg::P_BANKS-1:0] - head_q;
         bank_push[b] = ({1'b0, tail_dist} < push_size);
         bank_pop[b] = ({1'b0, head_dist} < pop_size);
         bank_push_entry[b] = lane_entry[tail_dist];
      end
   end

   // Tag each lane would receive if pushed now
   always_comb
   begin
      logic [rob_pkg::P_BANKS-1:0] fb;

      for (int k = 0; k < rob_pkg::BANKS; k++)
      begin
         fb = tail_q + k[rob_pkg::P_BANKS-1:0];
         free_bank[k] = fb;
         free_id[k] = bank_wr_slot[fb];
      end
   end

   // Banks rotated onto commit lanes with the oldest at lane 0
   always_comb
   begin
      logic [rob_pkg::P_BANKS-1:0] hb;

      for (int k = 0; k < rob_pkg::BANKS; k++)
      begin
         hb = head_q + k[rob_pkg::P_BANKS-1:0];
         cmt_valid[k] = bank_head_valid[hb];
         cmt_pc[k] = bank_head_entry[hb].pc;
         cmt_lrd[k] = bank_head_entry[hb].lrd;
         cmt_prd[k] = bank_head_entry[hb].prd;
         cmt_prd_we[k] = bank_head_entry[hb].prd_we;
         cmt_pfree[k] = bank_head_entry[hb].pfree;
         cmt_fls[k] = bank_head_fls[hb];
         cmt_exc[k] = bank_head_exc[hb];
         cmt_value[k] = bank_head_value[hb];
      end
   end

endmodule

/* design/rob_top.sv */
// Banked reorder buffer top
`timescale 1ns/1ns

module rob_top
(
   input  logic                                           clk,
   input  logic                                           rst_n,
   input  logic                                           flush,
   // Issue
   input  logic [rob_pkg::P_BANKS:0]                      rob_push_size,
   input  logic [rob_pkg::BANKS*rob_pkg::PC_W-1:0]        rob_push_pc,
   input  logic [rob_pkg::BANKS*rob_pkg::LRF_AW-1:0]      rob_push_lrd,
   input  logic [rob_pkg::BANKS*rob_pkg::PRF_AW-1:0]      rob_push_prd,
   input  logic [rob_pkg::BANKS-1:0]                      rob_push_prd_we,
   input  logic [rob_pkg::BANKS*rob_pkg::PRF_AW-1:0]      rob_push_pfree,
   output logic                                           rob_ready,
   output logic [rob_pkg::BANKS*rob_pkg::P_ROB_DEPTH-1:0] rob_free_id,
   output logic [rob_pkg::BANKS*rob_pkg::P_BANKS-1:0]     rob_free_bank,
   // Writeback
   input  logic [rob_pkg::WB_LANES-1:0]                      wb_valid,
   input  logic [rob_pkg::WB_LANES*rob_pkg::P_BANKS-1:0]     wb_rob_bank,
   input  logic [rob_pkg::WB_LANES*rob_pkg::P_ROB_DEPTH-1:0] wb_rob_id,
   input  logic [rob_pkg::WB_LANES-1:0]                      wb_fls,
   input  logic [rob_pkg::WB_LANES-1:0]                      wb_exc,
   input  logic [rob_pkg::WB_LANES*rob_pkg::DW-1:0]          wb_value,
   // Commit
   output logic [rob_pkg::BANKS-1:0]                      cmt_valid,
   output logic [rob_pkg::BANKS*rob_pkg::PC_W-1:0]        cmt_pc,
   output logic [rob_pkg::BANKS*rob_pkg::LRF_AW-1:0]      cmt_lrd,
   output logic [rob_pkg::BANKS*rob_pkg::PRF_AW-1:0]      cmt_prd,
   output logic [rob_pkg::BANKS-1:0]                      cmt_prd_we,
   output logic [rob_pkg::BANKS*rob_pkg::PRF_AW-1:0]      cmt_pfree,
   output logic [rob_pkg::BANKS-1:0]                      cmt_fls,
   output logic [rob_pkg::BANKS-1:0]                      cmt_exc,
   output logic [rob_pkg::BANKS*rob_pkg::DW-1:0]          cmt_value,
   input  logic [rob_pkg::P_BANKS:0]                      cmt_pop_size
);

   logic [rob_pkg::BANKS-1:0]                            bank_push;
   rob_pkg::rob_entry_t [rob_pkg::BANKS-1:0]             bank_push_entry;
   logic [rob_pkg::BANKS-1:0]                            bank_pop;
   logic [rob_pkg::BANKS-1:0]                            bank_wb;
   logic [rob_pkg::BANKS-1:0][rob_pkg::P_ROB_DEPTH-1:0]  bank_wb_id;
   logic [rob_pkg::BANKS-1:0]                            bank_wb_fls;
   logic [rob_pkg::BANKS-1:0]                            bank_wb_exc;
   rob_pkg::rob_value_t [rob_pkg::BANKS-1:0]             bank_wb_value;
   logic [rob_pkg::BANKS-1:0]                            bank_not_full;
   logic [rob_pkg::BANKS-1:0][rob_pkg::P_ROB_DEPTH-1:0]  bank_wr_slot;
   logic [rob_pkg::BANKS-1:0]                            bank_head_valid;
   rob_pkg::rob_entry_t [rob_pkg::BANKS-1:0]             bank_head_entry;
   logic [rob_pkg::BANKS-1:0]                            bank_head_fls;
   logic [rob_pkg::BANKS-1:0]                            bank_head_exc;
   rob_pkg::rob_value_t [rob_pkg::BANKS-1:0]             bank_head_value;

   rob_ring_ctrl i_rob_ring_ctrl (
      .clk             (clk),
      .rst_n           (rst_n),
      .flush           (flush),
      .push_size       (rob_push_size),
      .pop_size        (cmt_pop_size),
      .push_pc         (rob_push_pc),
      .push_lrd        (rob_push_lrd),
      .push_prd        (rob_push_prd),
      .push_prd_we     (rob_push_prd_we),
      .push_pfree      (rob_push_pfree),
      .bank_wr_slot    (bank_wr_slot),
      .bank_push       (bank_push),
      .bank_push_entry (bank_push_entry),
      .bank_pop        (bank_pop),
      .free_id         (rob_free_id),
      .free_bank       (rob_free_bank),
      .bank_head_valid (bank_head_valid),
      .bank_head_entry (bank_head_entry),
      .bank_head_fls   (bank_head_fls),
      .bank_head_exc   (bank_head_exc),
      .bank_head_value (bank_head_value),
      .cmt_valid       (cmt_valid),
      .cmt_pc          (cmt_pc),
      .cmt_lrd         (cmt_lrd),
      .cmt_prd         (cmt_prd),
      .cmt_prd_we      (cmt_prd_we),
      .cmt_pfree       (cmt_pfree),
      .cmt_fls         (cmt_fls),
      .cmt_exc         (cmt_exc),
      .cmt_value       (cmt_value)
   );

   rob_wb_route i_rob_wb_route (
      .wb_valid      (wb_valid),
      .wb_rob_bank   (wb_rob_bank),
      .wb_rob_id     (wb_rob_id),
      .wb_fls        (wb_fls),
      .wb_exc        (wb_exc),
      .wb_value      (wb_value),
      .bank_wb       (bank_wb),
      .bank_wb_id    (bank_wb_id),
      .bank_wb_fls   (bank_wb_fls),
      .bank_wb_exc   (bank_wb_exc),
      .bank_wb_value (bank_wb_value)
   );

   for (genvar b = 0; b < rob_pkg::BANKS; b++)
   begin : gen_bank
      rob_bank i_rob_bank (
         .clk        (clk),
         .rst_n      (rst_n),
         .flush      (flush),
         .push       (bank_push[b]),
         .push_entry (bank_push_entry[b]),
         .pop        (bank_pop[b]),
         .wb         (bank_wb[b]),
         .wb_id      (bank_wb_id[b]),
         .wb_fls     (bank_wb_fls[b]),
         .wb_exc     (bank_wb_exc[b]),
         .wb_value   (bank_wb_value[b]),
         .not_full   (bank_not_full[b]),
         .wr_slot    (bank_wr_slot[b]),
         .head_valid (bank_head_valid[b]),
         .head_entry (bank_head_entry[b]),
         .head_fls   (bank_head_fls[b]),
         .head_exc   (bank_head_exc[b]),
         .head_value (bank_head_value[b])
      );
   end

   // Any full bank stalls the whole issue group
   assign rob_ready = &bank_not_full;

endmodule

/* tests/rob_tb.sv */
// Reorder buffer testbench
`timescale 1ns/1ns

module rob_tb;

   localparam int RESET_CYCLES = 16;
   localparam int MIX_CYCLES = 400;
   localparam int FILL_CYCLES = 40;
   localparam int DRAIN_CYCLES = 160;
   localparam int TOTAL_CYCLES = RESET_CYCLES + MIX_CYCLES + FILL_CYCLES + DRAIN_CYCLES + 1;

   // One reorder buffer entry as the model sees it
   typedef struct {
      logic [rob_pkg::P_BANKS-1:0]     bank;
      logic [rob_pkg::P_ROB_DEPTH-1:0] id;
      bit                              done;
      bit                              fls;
      bit                              exc;
      rob_pkg::rob_value_t             value;
      rob_pkg::rob_entry_t             e;
   } model_ent_t;

   logic                                               clk = 1'b0;
   logic                                               rst_n;
   logic                                               flush;
   logic [rob_pkg::P_BANKS:0]                          rob_push_size;
   logic [rob_pkg::BANKS*rob_pkg::PC_W-1:0]            rob_push_pc;
   logic [rob_pkg::BANKS*rob_pkg::LRF_AW-1:0]          rob_push_lrd;
   logic [rob_pkg::BANKS*rob_pkg::PRF_AW-1:0]          rob_push_prd;
   logic [rob_pkg::BANKS-1:0]                          rob_push_prd_we;
   logic [rob_pkg::BANKS*rob_pkg::PRF_AW-1:0]          rob_push_pfree;
   logic                                               rob_ready;
   logic [rob_pkg::BANKS*rob_pkg::P_ROB_DEPTH-1:0]     rob_free_id;
   logic [rob_pkg::BANKS*rob_pkg::P_BANKS-1:0]         rob_free_bank;
   logic [rob_pkg::WB_LANES-1:0]                       wb_valid;
   logic [rob_pkg::WB_LANES*rob_pkg::P_BANKS-1:0]      wb_rob_bank;
   logic [rob_pkg::WB_LANES*rob_pkg::P_ROB_DEPTH-1:0]  wb_rob_id;
   logic [rob_pkg::WB_LANES-1:0]                       wb_fls;
   logic [rob_pkg::WB_LANES-1:0]                       wb_exc;
   logic [rob_pkg::WB_LANES*rob_pkg::DW-1:0]           wb_value;
   logic [rob_pkg::BANKS-1:0]                          cmt_valid;
   logic [rob_pkg::BANKS*rob_pkg::PC_W-1:0]            cmt_pc;
   logic [rob_pkg::BANKS*rob_pkg::LRF_AW-1:0]          cmt_lrd;
   logic [rob_pkg::BANKS*rob_pkg::PRF_AW-1:0]          cmt_prd;
   logic [rob_pkg::BANKS-1:0]                          cmt_prd_we;
   logic [rob_pkg::BANKS*rob_pkg::PRF_AW-1:0]          cmt_pfree;
   logic [rob_pkg::BANKS-1:0]                          cmt_fls;
   logic [rob_pkg::BANKS-1:0]                          cmt_exc;
   logic [rob_pkg::BANKS*rob_pkg::DW-1:0]              cmt_value;
   logic [rob_pkg::P_BANKS:0]                          cmt_pop_size;

   // Model state with the oldest entry at the queue front
   model_ent_t                      q[$];
   logic [rob_pkg::P_BANKS-1:0]     tail_bank;
   logic [rob_pkg::P_ROB_DEPTH-1:0] next_slot [rob_pkg::BANKS];
   int                              bank_cnt [rob_pkg::BANKS];
   integer                          seed = 35;
   string                           phase;
   int                              flush_at;

   always #20 clk = ~clk;

   rob_top i_rob_top (.*);

   task automatic check(input string name, input logic [63:0] exp, input logic [63:0] act);
      if (exp !== act)
      begin
         $display("ERR %s %s expected %0h actual %0h", phase, name, exp, act);
         $display("Test FAILED");
         $fatal(1, "Value mismatch on %s", name);
      end
   endtask

   function automatic bit model_ready();
      for (int b = 0; b < rob_pkg::BANKS; b++)
      begin
         if (bank_cnt[b] >= rob_pkg::ROB_DEPTH)
            return 1'b0;
      end
      return 1'b1;
   endfunction

   task automatic model_clear();
      q.delete();
      tail_bank = '0;
      for (int b = 0; b < rob_pkg::BANKS; b++)
      begin
         next_slot[b] = '0;
         bank_cnt[b] = 0;
      end
   endtask

   task automatic check_outputs();
      logic [rob_pkg::P_BANKS-1:0] b;
      bit                          v;

      check("rob_ready", model_ready(), rob_ready);
      for (int k = 0; k < rob_pkg::BANKS; k++)
      begin
         b = tail_bank + k[rob_pkg::P_BANKS-1:0];
         check("free_bank", b, rob_free_bank[k*rob_pkg::P_BANKS +: rob_pkg::P_BANKS]);
         check("free_id", next_slot[b], rob_free_id[k*rob_pkg::P_ROB_DEPTH +: rob_pkg::P_ROB_DEPTH]);
         v = (k < q.size()) && q[k].done;
         check("cmt_valid", v, cmt_valid[k]);
         if (v)
         begin
            check("cmt_pc", q[k].e.pc, cmt_pc[k*rob_pkg::PC_W +: rob_pkg::PC_W]);
            check("cmt_lrd", q[k].e.lrd, cmt_lrd[k*rob_pkg::LRF_AW +: rob_pkg::LRF_AW]);
            check("cmt_prd", q[k].e.prd, cmt_prd[k*rob_pkg::PRF_AW +: rob_pkg::PRF_AW]);
            check("cmt_prd_we", q[k].e.prd_we, cmt_prd_we[k]);
            check("cmt_pfree", q[k].e.pfree, cmt_pfree[k*rob_pkg::PRF_AW +: rob_pkg::PRF_AW]);
            check("cmt_fls", q[k].fls, cmt_fls[k]);
            check("cmt_exc", q[k].exc, cmt_exc[k]);
            check("cmt_value", q[k].value, cmt_value[k*rob_pkg::DW +: rob_pkg::DW]);
         end
      end
   endtask

   task automatic drive_cycle(input bit allow_pop, input bit heavy, input bit do_flush);
      int unsigned                 r;
      int unsigned                 r2;
      int                          run;
      int                          pops;
      int                          psz;
      int                          j;
      int                          sel [rob_pkg::WB_LANES];
      logic [rob_pkg::P_BANKS-1:0] b;
      model_ent_t                  ent;

      // Pop never exceeds the leading run of completed entries
      run = 0;
      while (run < rob_pkg::BANKS && run < q.size() && q[run].done)
         run++;
      r = $random(seed);
      pops = allow_pop ? int'(r % (run + 1)) : 0;
      cmt_pop_size = pops[rob_pkg::P_BANKS:0];

      // Writebacks pick pending entries in distinct banks
      wb_valid = '0;
      wb_rob_bank = '0;
      wb_rob_id = '0;
      wb_fls = '0;
      wb_exc = '0;
      for (int l = 0; l < rob_pkg::WB_LANES; l++)
      begin
         sel[l] = -1;
         r = $random(seed);
         wb_value[l*rob_pkg::DW +: rob_pkg::DW] = r[31:16];
         if (r[0] && q.size() > 0)
         begin
            for (int n = 0; n < q.size(); n++)
            begin
               j = (int'(r[15:8]) + n) % q.size();
               if (!q[j].done && (l == 0 || sel[0] < 0 || q[j].bank != q[sel[0]].bank))
               begin
                  sel[l] = j;
                  break;
               end
            end
         end
         if (sel[l] >= 0)
         begin
            wb_valid[l] = 1'b1;
            wb_rob_bank[l*rob_pkg::P_BANKS +: rob_pkg::P_BANKS] = q[sel[l]].bank;
            wb_rob_id[l*rob_pkg::P_ROB_DEPTH +: rob_pkg::P_ROB_DEPTH] = q[sel[l]].id;
            wb_fls[l] = r[1];
            wb_exc[l] = r[2];
         end
      end

      // Issue lanes are pushed only while the buffer is ready
      r = $random(seed);
      psz = heavy ? 3 + int'(r % 2) : int'(r % 5);
      if (!model_ready())
         psz = 0;
      rob_push_size = psz[rob_pkg::P_BANKS:0];
      for (int k = 0; k < rob_pkg::BANKS; k++)
      begin
         r = $random(seed);
         r2 = $random(seed);
         rob_push_pc[k*rob_pkg::PC_W +: rob_pkg::PC_W] = r[15:0];
         rob_push_lrd[k*rob_pkg::LRF_AW +: rob_pkg::LRF_AW] = r[20:16];
         rob_push_prd[k*rob_pkg::PRF_AW +: rob_pkg::PRF_AW] = r[26:21];
         rob_push_prd_we[k] = r[27];
         rob_push_pfree[k*rob_pkg::PRF_AW +: rob_pkg::PRF_AW] = r2[5:0];
      end
      flush = do_flush;

      // Model moves to the state after the coming edge
      if (do_flush)
         model_clear();
      else
      begin
         for (int l = 0; l < rob_pkg::WB_LANES; l++)
         begin
            if (sel[l] >= 0)
            begin
               q[sel[l]].done = 1'b1;
               q[sel[l]].fls = wb_fls[l];
               q[sel[l]].exc = wb_exc[l];
               q[sel[l]].value = wb_value[l*rob_pkg::DW +: rob_pkg::DW];
            end
         end
         repeat (pops)
         begin
            bank_cnt[q[0].bank]--;
            void'(q.pop_front());
         end
         for (int k = 0; k < psz; k++)
         begin
            b = tail_bank + k[rob_pkg::P_BANKS-1:0];
            ent.bank = b;
            ent.id = next_slot[b];
            ent.done = 1'b0;
            ent.fls = 1'b0;
            ent.exc = 1'b0;
            ent.value = '0;
            ent.e.pc = rob_push_pc[k*rob_pkg::PC_W +: rob_pkg::PC_W];
            ent.e.lrd = rob_push_lrd[k*rob_pkg::LRF_AW +: rob_pkg::LRF_AW];
            ent.e.prd = rob_push_prd[k*rob_pkg::PRF_AW +: rob_pkg::PRF_AW];
            ent.e.prd_we = rob_push_prd_we[k];
            ent.e.pfree = rob_push_pfree[k*rob_pkg::PRF_AW +: rob_pkg::PRF_AW];
            q.push_back(ent);
            next_slot[b] = next_slot[b] + 1'b1;
            bank_cnt[b]++;
         end
         tail_bank = tail_bank + rob_push_size[rob_pkg::P_BANKS-1:0];
      end
   endtask

   // Watchdog
   initial
   begin
      #(2 * TOTAL_CYCLES * 40);
      $display("Timeout: the run took more than twice its planned %0d cycles", TOTAL_CYCLES);
      $display("Test FAILED");
      $fatal(1, "Watchdog expired");
   end

   initial
   begin
      rst_n = 1'b0;
      flush = 1'b0;
      rob_push_size = '0;
      rob_push_pc = '0;
      rob_push_lrd = '0;
      rob_push_prd = '0;
      rob_push_prd_we = '0;
      rob_push_pfree = '0;
      wb_valid = '0;
      wb_rob_bank = '0;
      wb_rob_id = '0;
      wb_fls = '0;
      wb_exc = '0;
      wb_value = '0;
      cmt_pop_size = '0;
      model_clear();
      flush_at = 50 + ({$random(seed)} % 300);
      repeat (RESET_CYCLES) @(negedge clk);
      rst_n = 1'b1;

      // Mixed traffic with one flush pulse
      phase = "mixed";
      for (int c = 0; c < MIX_CYCLES; c++)
      begin
         @(negedge clk);
         check_outputs();
         drive_cycle(1'b1, 1'b0, c == flush_at);
      end

      // Heavy issue with no commit fills every bank
      phase = "fill";
      for (int c = 0; c < FILL_CYCLES; c++)
      begin
         @(negedge clk);
         check_outputs();
         drive_cycle(1'b0, 1'b1, 1'b0);
      end

      phase = "drain";
      for (int c = 0; c < DRAIN_CYCLES; c++)
      begin
         @(negedge clk);
         check_outputs();
         drive_cycle(1'b1, 1'b0, 1'b0);
      end
      @(negedge clk);
      check_outputs();

      $display("Test OK");
      $finish;
   end

endmodule

/* vlog.f */
design/rob_pkg.sv
design/rob_slot_ram.sv
design/rob_bank.sv
design/rob_wb_route.sv
design/rob_ring_ctrl.sv
design/rob_top.sv
tests/rob_tb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary -Wno-fatal --top-module rob_tb -f vlog.f -o rob_sim
	@out="$$(./obj_dir/rob_sim)"; echo "$$out"; echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf obj_dir
